// File: rtl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int xlen        = 32;
    localparam int tlb_entries = 8;
    localparam int tlb_idx_w   = $clog2(tlb_entries);
    localparam int dmem_words  = 1024;
    localparam int mmio_regs   = 4;

    typedef enum logic [1:0] {
        bt_byte = 2'd0,
        bt_half = 2'd1,
        bt_word = 2'd2
    } byte_type_t;

    typedef enum logic [1:0] {
        dc_nop = 2'd0,
        dc_rd  = 2'd1,
        dc_wr  = 2'd2
    } dc_op_t;

    typedef enum logic [2:0] {
        excp_none = 3'd0,
        excp_ale  = 3'd1,
        excp_tlbr = 3'd2,
        excp_pil  = 3'd3,
        excp_pis  = 3'd4,
        excp_ppi  = 3'd5,
        excp_pme  = 3'd6
    } excp_code_t;

    typedef struct packed {
        logic             valid;
        excp_code_t       code;
        logic [xlen-1:0]  badv;
    } excp_pass_t;

    typedef struct packed {
        logic [19:0] vppn;
        logic [19:0] ppn;
        logic [9:0]  asid;
        logic        g;
        logic        v;
        logic        d;
        logic        mat;
        logic [1:0]  plv;
    } tlb_entry_t;

    // Direct-mapped window
    typedef struct packed {
        logic       plv0;
        logic       plv3;
        logic       mat;
        logic [2:0] vseg;
        logic [2:0] pseg;
    } dmw_t;

    typedef struct packed {
        logic       da;
        logic       datm;
        logic [1:0] plv;
        logic [9:0] asid;
        dmw_t       dmw0;
        dmw_t       dmw1;
    } csr_t;

    typedef struct packed {
        logic            is_flush;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] ex_out;
        logic            is_mem;
        logic            is_store;
        logic            is_signed;
        byte_type_t      byte_type;
        logic            is_wr_rd;
        logic [4:0]      rd;
        logic [xlen-1:0] rkd_data;
    } ex_mem1_pass_t;

    typedef struct packed {
        logic            is_flush;
        logic [xlen-1:0] ex_out;
        logic            is_mem;
        logic            is_store;
        logic            is_signed;
        byte_type_t      byte_type;
        logic            is_wr_rd;
        logic [4:0]      rd;
        logic [1:0]      byte_off;
    } mem1_mem2_pass_t;

endpackage

`default_nettype wire

// File: rtl/dcache_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dcache_req_if;

    mem_pkg::dc_op_t          op;
    logic [11:0]              idx;
    logic [mem_pkg::xlen-1:0] pa;
    logic                     is_cached;
    mem_pkg::byte_type_t      byte_type;
    logic [mem_pkg::xlen-1:0] wdata;

    // Stage one issues, data store accepts every cycle
    modport master (output op, idx, pa, is_cached, byte_type, wdata);
    modport slave  (input  op, idx, pa, is_cached, byte_type, wdata);

endinterface

`default_nettype wire

// File: rtl/tlb_array.sv
`timescale 1ns/1ps
`default_nettype none

module tlb_array (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          tlbwr_en,
    input  logic [mem_pkg::tlb_idx_w-1:0] tlbwr_idx,
    input  mem_pkg::tlb_entry_t           tlbwr_entry,
    input  logic [19:0]                   vppn,
    input  logic [9:0]                    asid,
    output logic                          hit,
    output mem_pkg::tlb_entry_t           hit_entry
);

    mem_pkg::tlb_entry_t               entries [mem_pkg::tlb_entries];
    logic [mem_pkg::tlb_entries-1:0]   match;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < mem_pkg::tlb_entries; i++) begin
                entries[i].v <= 1'b0;
            end
        end else if (tlbwr_en) begin
            entries[tlbwr_idx] <= tlbwr_entry;
        end
    end

    // Global entries ignore the ASID
    always_comb begin
        for (int i = 0; i < mem_pkg::tlb_entries; i++) begin
            match[i] = (entries[i].vppn == vppn) &&
                       (entries[i].g || (entries[i].asid == asid));
        end
    end

    // Walk down so the lowest index wins
    always_comb begin
        hit       = 1'b0;
        hit_entry = '0;
        for (int i = mem_pkg::tlb_entries - 1; i >= 0; i--) begin
            if (match[i]) begin
                hit       = 1'b1;
                hit_entry = entries[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/addr_trans.sv
`timescale 1ns/1ps
`default_nettype none

module addr_trans (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [mem_pkg::xlen-1:0]      va,
    input  logic                          is_store,
    input  mem_pkg::byte_type_t           byte_type,
    input  mem_pkg::csr_t                 csr,
    input  logic                          tlbwr_en,
    input  logic [mem_pkg::tlb_idx_w-1:0] tlbwr_idx,
    input  mem_pkg::tlb_entry_t           tlbwr_entry,
    output logic [mem_pkg::xlen-1:0]      pa,
    output logic                          is_cached,
    output mem_pkg::excp_pass_t           excp
);

    logic                 misalign;
    logic                 win0_hit;
    logic                 win1_hit;
    logic                 tlb_hit;
    mem_pkg::tlb_entry_t  tlb_e;
    mem_pkg::excp_code_t  code;

    function automatic logic dmw_hit(mem_pkg::dmw_t w, logic [2:0] vseg, logic [1:0] plv);
        return (w.vseg == vseg) && ((plv == 2'd0 && w.plv0) || (plv == 2'd3 && w.plv3));
    endfunction

    tlb_array u_tlb (
        .clk         (clk),
        .rst_n       (rst_n),
        .tlbwr_en    (tlbwr_en),
        .tlbwr_idx   (tlbwr_idx),
        .tlbwr_entry (tlbwr_entry),
        .vppn        (va[31:12]),
        .asid        (csr.asid),
        .hit         (tlb_hit),
        .hit_entry   (tlb_e)
    );

    assign misalign = ((byte_type == mem_pkg::bt_half) && va[0]) ||
                      ((byte_type == mem_pkg::bt_word) && (va[1:0] != 2'b00));
    assign win0_hit = dmw_hit(csr.dmw0, va[31:29], csr.plv);
    assign win1_hit = dmw_hit(csr.dmw1, va[31:29], csr.plv);

    always_comb begin
        pa        = va;
        is_cached = 1'b0;
        code      = mem_pkg::excp_none;
        if (misalign) begin
            code = mem_pkg::excp_ale;
        end else if (csr.da) begin
            pa        = va;
            is_cached = csr.datm;
        end else if (win0_hit) begin
            pa        = {csr.dmw0.pseg, va[28:0]};
            is_cached = csr.dmw0.mat;
        end else if (win1_hit) begin
            pa        = {csr.dmw1.pseg, va[28:0]};
            is_cached = csr.dmw1.mat;
        end else if (!tlb_hit) begin
            code = mem_pkg::excp_tlbr;
        end else if (!tlb_e.v) begin
            code = is_store ? mem_pkg::excp_pis : mem_pkg::excp_pil;
        end else if (csr.plv > tlb_e.plv) begin
            code = mem_pkg::excp_ppi;
        end else if (is_store && !tlb_e.d) begin
            code = mem_pkg::excp_pme;
        end else begin
            pa        = {tlb_e.ppn, va[11:0]};
            is_cached = tlb_e.mat;
        end
    end

    // Bad address is always the virtual one
    assign excp.valid = (code != mem_pkg::excp_none);
    assign excp.code  = code;
    assign excp.badv  = va;

endmodule

`default_nettype wire

// File: rtl/memory1_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory1_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          is_stall,
    input  logic                          is_flush,
    input  mem_pkg::ex_mem1_pass_t        pass_in,
    input  mem_pkg::excp_pass_t           excp_in,
    input  mem_pkg::csr_t                 csr,
    input  logic                          tlbwr_en,
    input  logic [mem_pkg::tlb_idx_w-1:0] tlbwr_idx,
    input  mem_pkg::tlb_entry_t           tlbwr_entry,
    output logic                          fwd_valid,
    output logic [4:0]                    fwd_rd,
    output logic [mem_pkg::xlen-1:0]      fwd_data,
    dcache_req_if.master                  dc,
    output mem_pkg::mem1_mem2_pass_t      pass_out,
    output mem_pkg::excp_pass_t           excp_out
);

    mem_pkg::ex_mem1_pass_t   pass_r;
    mem_pkg::excp_pass_t      excp_r;
    mem_pkg::excp_pass_t      addr_excp;
    logic [mem_pkg::xlen-1:0] pa;
    logic                     is_cached;
    logic                     mem1_flush;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pass_r.is_flush <= 1'b1;
            excp_r.valid    <= 1'b0;
        end else if (!is_stall) begin
            pass_r <= pass_in;
            excp_r <= excp_in;
        end
    end

    assign mem1_flush = is_flush || pass_r.is_flush;

    // Loads are not forwarded here, their data comes back in stage two
    assign fwd_valid = pass_r.is_wr_rd && !mem1_flush && !(pass_r.is_mem && !pass_r.is_store);
    assign fwd_rd    = pass_r.rd;
    assign fwd_data  = pass_r.ex_out;

    addr_trans u_addr_trans (
        .clk         (clk),
        .rst_n       (rst_n),
        .va          (pass_r.ex_out),
        .is_store    (pass_r.is_store),
        .byte_type   (pass_r.byte_type),
        .csr         (csr),
        .tlbwr_en    (tlbwr_en),
        .tlbwr_idx   (tlbwr_idx),
        .tlbwr_entry (tlbwr_entry),
        .pa          (pa),
        .is_cached   (is_cached),
        .excp        (addr_excp)
    );

    // Earlier exception wins, address faults only count for memory ops
    always_comb begin
        if (excp_r.valid) begin
            excp_out = excp_r;
        end else if (pass_r.is_mem) begin
            excp_out = addr_excp;
        end else begin
            excp_out = '0;
        end
    end

    always_comb begin
        dc.op = mem_pkg::dc_nop;
        if (!mem1_flush && !is_stall && pass_r.is_mem && !excp_out.valid) begin
            dc.op = pass_r.is_store ? mem_pkg::dc_wr : mem_pkg::dc_rd;
        end
    end

    assign dc.idx       = pass_r.ex_out[11:0];
    assign dc.pa        = pa;
    assign dc.is_cached = is_cached;
    assign dc.byte_type = pass_r.byte_type;
    assign dc.wdata     = pass_r.rkd_data;

    assign pass_out.is_flush  = mem1_flush;
    assign pass_out.ex_out    = pass_r.ex_out;
    assign pass_out.is_mem    = pass_r.is_mem;
    assign pass_out.is_store  = pass_r.is_store;
    assign pass_out.is_signed = pass_r.is_signed;
    assign pass_out.byte_type = pass_r.byte_type;
    assign pass_out.is_wr_rd  = pass_r.is_wr_rd;
    assign pass_out.rd        = pass_r.rd;
    assign pass_out.byte_off  = pass_r.ex_out[1:0];

endmodule

`default_nettype wire

// File: rtl/data_store.sv
`timescale 1ns/1ps
`default_nettype none

module data_store (
    input  logic                     clk,
    input  logic                     rst_n,
    dcache_req_if.slave              dc,
    output logic [mem_pkg::xlen-1:0] rdata
);

    logic [mem_pkg::xlen-1:0] ram  [mem_pkg::dmem_words];
    logic [mem_pkg::xlen-1:0] mmio [mem_pkg::mmio_regs];
    logic [3:0]               be;
    logic [mem_pkg::xlen-1:0] wdata_rep;
    logic                     is_wr;

    // Lane enables from size and offset, data copied to every lane
    always_comb begin
        case (dc.byte_type)
            mem_pkg::bt_byte: begin
                be        = 4'b0001 << dc.idx[1:0];
                wdata_rep = {4{dc.wdata[7:0]}};
            end
            mem_pkg::bt_half: begin
                be        = 4'b0011 << {dc.idx[1], 1'b0};
                wdata_rep = {2{dc.wdata[15:0]}};
            end
            default: begin
                be        = 4'b1111;
                wdata_rep = dc.wdata;
            end
        endcase
    end

    assign is_wr = (dc.op == mem_pkg::dc_wr);

    always_ff @(posedge clk) begin
        if (is_wr && dc.is_cached) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    ram[dc.idx[11:2]][i*8 +: 8] <= wdata_rep[i*8 +: 8];
                end
            end
        end
    end

    // Uncached device registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < mem_pkg::mmio_regs; r++) begin
                mmio[r] <= '0;
            end
        end else if (is_wr && !dc.is_cached) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mmio[dc.pa[3:2]][i*8 +: 8] <= wdata_rep[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dc.op == mem_pkg::dc_rd) begin
            rdata <= dc.is_cached ? ram[dc.idx[11:2]] : mmio[dc.pa[3:2]];
        end
    end

endmodule

`default_nettype wire

// File: rtl/memory2_stage.sv
`timescale 1ns/1ps
`default_nettype none

module memory2_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     is_stall,
    input  mem_pkg::mem1_mem2_pass_t pass_in,
    input  mem_pkg::excp_pass_t      excp_in,
    input  logic [mem_pkg::xlen-1:0] rdata,
    output logic                     wb_valid,
    output logic [4:0]               wb_rd,
    output logic [mem_pkg::xlen-1:0] wb_data,
    output mem_pkg::excp_pass_t      excp_out
);

    mem_pkg::mem1_mem2_pass_t pass_r;
    mem_pkg::excp_pass_t      excp_r;
    logic                     live;
    logic                     is_load;
    logic [7:0]               rbyte;
    logic [15:0]              rhalf;
    logic [mem_pkg::xlen-1:0] load_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pass_r.is_flush <= 1'b1;
            excp_r.valid    <= 1'b0;
        end else if (!is_stall) begin
            pass_r <= pass_in;
            excp_r <= excp_in;
        end
    end

    assign live    = !pass_r.is_flush;
    assign is_load = pass_r.is_mem && !pass_r.is_store;

    // Pick the addressed lane out of the read word
    assign rbyte = rdata[{pass_r.byte_off, 3'b000} +: 8];
    assign rhalf = rdata[{pass_r.byte_off[1], 4'b0000} +: 16];

    always_comb begin
        case (pass_r.byte_type)
            mem_pkg::bt_byte: load_data = {{24{pass_r.is_signed && rbyte[7]}}, rbyte};
            mem_pkg::bt_half: load_data = {{16{pass_r.is_signed && rhalf[15]}}, rhalf};
            default:          load_data = rdata;
        endcase
    end

    assign wb_valid = live && pass_r.is_wr_rd && !excp_r.valid;
    assign wb_rd    = pass_r.rd;
    assign wb_data  = is_load ? load_data : pass_r.ex_out;

    // A flushed item reports no exception
    always_comb begin
        excp_out       = excp_r;
        excp_out.valid = excp_r.valid && live;
    end

endmodule

`default_nettype wire

// File: rtl/mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          is_stall,
    input  logic                          is_flush,
    input  mem_pkg::ex_mem1_pass_t        pass_in,
    input  mem_pkg::excp_pass_t           excp_in,
    input  mem_pkg::csr_t                 csr,
    input  logic                          tlbwr_en,
    input  logic [mem_pkg::tlb_idx_w-1:0] tlbwr_idx,
    input  mem_pkg::tlb_entry_t           tlbwr_entry,
    output logic                          fwd_valid,
    output logic [4:0]                    fwd_rd,
    output logic [mem_pkg::xlen-1:0]      fwd_data,
    output logic                          wb_valid,
    output logic [4:0]                    wb_rd,
    output logic [mem_pkg::xlen-1:0]      wb_data,
    output mem_pkg::excp_pass_t           excp_out
);

    mem_pkg::mem1_mem2_pass_t m1_pass;
    mem_pkg::excp_pass_t      m1_excp;
    logic [mem_pkg::xlen-1:0] rdata;

    dcache_req_if dc ();

    memory1_stage u_mem1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .is_stall    (is_stall),
        .is_flush    (is_flush),
        .pass_in     (pass_in),
        .excp_in     (excp_in),
        .csr         (csr),
        .tlbwr_en    (tlbwr_en),
        .tlbwr_idx   (tlbwr_idx),
        .tlbwr_entry (tlbwr_entry),
        .fwd_valid   (fwd_valid),
        .fwd_rd      (fwd_rd),
        .fwd_data    (fwd_data),
        .dc          (dc.master),
        .pass_out    (m1_pass),
        .excp_out    (m1_excp)
    );

    data_store u_store (
        .clk   (clk),
        .rst_n (rst_n),
        .dc    (dc.slave),
        .rdata (rdata)
    );

    memory2_stage u_mem2 (
        .clk      (clk),
        .rst_n    (rst_n),
        .is_stall (is_stall),
        .pass_in  (m1_pass),
        .excp_in  (m1_excp),
        .rdata    (rdata),
        .wb_valid (wb_valid),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .excp_out (excp_out)
    );

endmodule

`default_nettype wire

// File: dv/mem_tb_table.svh
`ifndef MEM_TB_TABLE_SVH
`define MEM_TB_TABLE_SVH

// Columns: mode, kind, flush, incoming cause, va, size, signed, rd, expected pa, expected cause
// mode 0 direct cached, 1 direct uncached, 2 mapped at plv0, 3 mapped at plv3
// kind 0 alu, 1 load, 2 store; size 0 byte, 1 half, 2 word
typedef struct packed {
    logic [1:0]  mode;
    logic [1:0]  kind;
    logic        flush;
    logic [2:0]  in_exc;
    logic [31:0] va;
    logic [1:0]  bt;
    logic        sgn;
    logic [4:0]  rd;
    logic [31:0] pa;
    logic [2:0]  exc;
} row_t;

// vppn, ppn, asid, g, v, d, mat, plv
localparam mem_pkg::tlb_entry_t tlb_fill [5] = '{
    '{20'h00010, 20'h00020, 10'd5, 1'b0, 1'b1, 1'b1, 1'b1, 2'd3},
    '{20'h00011, 20'h00021, 10'd0, 1'b1, 1'b0, 1'b1, 1'b1, 2'd3},
    '{20'h00012, 20'h00022, 10'd0, 1'b1, 1'b1, 1'b0, 1'b1, 2'd3},
    '{20'h00013, 20'h00023, 10'd0, 1'b1, 1'b1, 1'b1, 1'b1, 2'd0},
    '{20'h00014, 20'h00024, 10'd3, 1'b0, 1'b1, 1'b1, 1'b1, 2'd3}
};

localparam int n_rows = 29;
localparam row_t rows [n_rows] = '{
    '{2'd0, 2'd2, 1'b0, 3'd0, 32'h0000_0100, 2'd2, 1'b0, 5'd0,  32'h0000_0100, 3'd0},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0000_0100, 2'd2, 1'b0, 5'd1,  32'h0000_0100, 3'd0},
    '{2'd0, 2'd2, 1'b0, 3'd0, 32'h0000_0106, 2'd1, 1'b0, 5'd0,  32'h0000_0106, 3'd0},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0000_0106, 2'd1, 1'b1, 5'd2,  32'h0000_0106, 3'd0},
    '{2'd0, 2'd2, 1'b0, 3'd0, 32'h0000_0109, 2'd0, 1'b0, 5'd0,  32'h0000_0109, 3'd0},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0000_0109, 2'd0, 1'b1, 5'd3,  32'h0000_0109, 3'd0},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0000_0109, 2'd0, 1'b0, 5'd4,  32'h0000_0109, 3'd0},
    // Device registers
    '{2'd1, 2'd2, 1'b0, 3'd0, 32'h0000_1004, 2'd2, 1'b0, 5'd0,  32'h0000_1004, 3'd0},
    '{2'd1, 2'd1, 1'b0, 3'd0, 32'h0000_1004, 2'd2, 1'b0, 5'd5,  32'h0000_1004, 3'd0},
    '{2'd1, 2'd1, 1'b0, 3'd0, 32'h0000_1006, 2'd0, 1'b1, 5'd6,  32'h0000_1006, 3'd0},
    // Misaligned stores must leave word 0x100 alone
    '{2'd0, 2'd2, 1'b0, 3'd0, 32'h0000_0102, 2'd2, 1'b0, 5'd0,  32'h0000_0102, 3'd1},
    '{2'd0, 2'd2, 1'b0, 3'd0, 32'h0000_0101, 2'd1, 1'b0, 5'd0,  32'h0000_0101, 3'd1},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0000_0100, 2'd2, 1'b0, 5'd7,  32'h0000_0100, 3'd0},
    '{2'd2, 2'd2, 1'b0, 3'd0, 32'ha000_0200, 2'd2, 1'b0, 5'd0,  32'h0000_0200, 3'd0},
    '{2'd2, 2'd1, 1'b0, 3'd0, 32'ha000_0200, 2'd2, 1'b0, 5'd8,  32'h0000_0200, 3'd0},
    '{2'd3, 2'd2, 1'b0, 3'd0, 32'h0001_0300, 2'd2, 1'b0, 5'd0,  32'h0002_0300, 3'd0},
    '{2'd3, 2'd1, 1'b0, 3'd0, 32'h0001_0302, 2'd1, 1'b0, 5'd9,  32'h0002_0302, 3'd0},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0002_0300, 2'd2, 1'b0, 5'd10, 32'h0002_0300, 3'd0},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0000_0200, 2'd2, 1'b0, 5'd11, 32'h0000_0200, 3'd0},
    // Page faults
    '{2'd3, 2'd1, 1'b0, 3'd0, 32'h0001_5000, 2'd2, 1'b0, 5'd12, 32'h0000_0000, 3'd2},
    // Non-global entry of another ASID does not hit
    '{2'd3, 2'd1, 1'b0, 3'd0, 32'h0001_4000, 2'd2, 1'b0, 5'd18, 32'h0000_0000, 3'd2},
    '{2'd3, 2'd1, 1'b0, 3'd0, 32'h0001_1000, 2'd2, 1'b0, 5'd13, 32'h0000_0000, 3'd3},
    '{2'd3, 2'd2, 1'b0, 3'd0, 32'h0001_1000, 2'd2, 1'b0, 5'd0,  32'h0000_0000, 3'd4},
    '{2'd3, 2'd2, 1'b0, 3'd0, 32'h0001_2000, 2'd2, 1'b0, 5'd0,  32'h0000_0000, 3'd6},
    '{2'd3, 2'd1, 1'b0, 3'd0, 32'h0001_3000, 2'd2, 1'b0, 5'd14, 32'h0000_0000, 3'd5},
    '{2'd0, 2'd1, 1'b0, 3'd3, 32'h0000_0103, 2'd2, 1'b0, 5'd15, 32'h0000_0103, 3'd3},
    '{2'd0, 2'd2, 1'b1, 3'd0, 32'h0000_0100, 2'd2, 1'b0, 5'd0,  32'h0000_0100, 3'd0},
    '{2'd0, 2'd1, 1'b0, 3'd0, 32'h0000_0100, 2'd2, 1'b0, 5'd16, 32'h0000_0100, 3'd0},
    '{2'd0, 2'd0, 1'b0, 3'd0, 32'h1234_5678, 2'd2, 1'b0, 5'd17, 32'h0000_0000, 3'd0}
};

`endif

// File: dv/mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_tb;

    `include "mem_tb_table.svh"

    logic                   clk;
    logic                   rst_n;
    logic                   is_stall;
    logic                   is_flush;
    mem_pkg::ex_mem1_pass_t pass_in;
    mem_pkg::excp_pass_t    excp_in;
    mem_pkg::csr_t          csr;
    logic                   tlbwr_en;
    logic [2:0]             tlbwr_idx;
    mem_pkg::tlb_entry_t    tlbwr_entry;
    logic                   fwd_valid;
    logic [4:0]             fwd_rd;
    logic [31:0]            fwd_data;
    logic                   wb_valid;
    logic [4:0]             wb_rd;
    logic [31:0]            wb_data;
    mem_pkg::excp_pass_t    excp_out;
    logic [15:0]            lfsr;
    logic [7:0]             shadow [logic [15:0]];
    logic [31:0]            exp_data [n_rows];

    mem_top DUT (.*);

    always #4 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic next_word(output logic [31:0] w);
        for (int i = 0; i < 32; i++) begin
            lfsr = lfsr_step(lfsr);
            w    = {w[30:0], lfsr[0]};
        end
    endtask

    function automatic mem_pkg::csr_t csr_for_mode(input logic [1:0] mode);
        mem_pkg::csr_t c;
        c      = '0;
        c.da   = (mode < 2'd2);
        c.datm = (mode == 2'd0);
        c.plv  = (mode == 2'd3) ? 2'd3 : 2'd0;
        c.asid = 10'd5;
        // Kernel window 0xa0000000 onto segment 0, cached
        c.dmw0 = '{plv0: 1'b1, plv3: 1'b0, mat: 1'b1, vseg: 3'b101, pseg: 3'b000};
        return c;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("ERR @%0t: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_fwd(input int j);
        logic exp_f;
        exp_f = !rows[j].flush && (rows[j].kind == 2'd0);
        assert (fwd_valid == exp_f && (!exp_f || (fwd_rd == rows[j].rd && fwd_data == rows[j].va)))
            else report_mismatch($sformatf("row %0d forward %b rd %0d data %h, expected %b",
                                           j, fwd_valid, fwd_rd, fwd_data, exp_f));
    endtask

    task automatic check_wb(input int j);
        logic exp_v;
        logic exp_e;
        exp_e = !rows[j].flush && (rows[j].exc != 3'd0);
        exp_v = !rows[j].flush && (rows[j].kind != 2'd2) && !exp_e;
        assert (wb_valid == exp_v && (!exp_v || (wb_rd == rows[j].rd && wb_data == exp_data[j])))
            else report_mismatch($sformatf("row %0d wb %b rd %0d data %h, expected %b %h",
                                           j, wb_valid, wb_rd, wb_data, exp_v, exp_data[j]));
        assert (excp_out.valid == exp_e &&
                (!exp_e || (excp_out.code == rows[j].exc && excp_out.badv == rows[j].va)))
            else report_mismatch($sformatf("row %0d cause %b/%0d, expected %b/%0d",
                                           j, excp_out.valid, excp_out.code, exp_e, rows[j].exc));
    endtask

    task automatic drive_row(input int k);
        row_t        r;
        logic [31:0] d;
        logic [31:0] v;
        logic [15:0] key;
        int          n;
        r = rows[k];
        next_word(d);
        pass_in = '{r.flush, 32'h0, r.va, r.kind != 2'd0, r.kind == 2'd2, r.sgn,
                    mem_pkg::byte_type_t'(r.bt), r.kind != 2'd2, r.rd, d};
        excp_in = '{r.in_exc != 3'd0, mem_pkg::excp_code_t'(r.in_exc), r.va};
        // Device registers live apart from the RAM in the byte model
        key = (r.mode == 2'd1) ? {12'h100, r.pa[3:0]} : {4'h0, r.pa[11:0]};
        n   = 1 << r.bt;
        if (r.kind == 2'd2 && !r.flush && r.exc == 3'd0) begin
            for (int i = 0; i < n; i++) begin
                shadow[key + 16'(i)] = d[8*i +: 8];
            end
        end
        exp_data[k] = r.va;
        if (r.kind == 2'd1 && r.exc == 3'd0) begin
            v = '0;
            for (int i = 0; i < n; i++) begin
                v[8*i +: 8] = shadow[key + 16'(i)];
            end
            if (r.sgn && n < 4 && v[8*n-1]) begin
                v = v | ~((32'd1 << (8*n)) - 32'd1);
            end
            exp_data[k] = v;
        end
    endtask

    initial begin
        int wait_cnt;
        clk              = 1'b0;
        rst_n            = 1'b0;
        is_stall         = 1'b0;
        is_flush         = 1'b0;
        pass_in          = '0;
        pass_in.is_flush = 1'b1;
        excp_in          = '0;
        csr              = '0;
        tlbwr_en         = 1'b0;
        tlbwr_idx        = '0;
        tlbwr_entry      = '0;
        lfsr             = 16'd1608;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < $size(tlb_fill); i++) begin
            tlbwr_en    = 1'b1;
            tlbwr_idx   = 3'(i);
            tlbwr_entry = tlb_fill[i];
            @(negedge clk);
        end
        tlbwr_en = 1'b0;
        wait_cnt = 0;
        while ((fwd_valid || wb_valid) && wait_cnt < 20) begin
            @(negedge clk);
            wait_cnt++;
        end
        assert (!fwd_valid && !wb_valid) else begin
            $display("Pipeline did not go idle within 20 cycles after reset");
            $display("Simulation FAILED");
            $fatal(1);
        end
        // Row k-1 sits in stage one and row k-2 in stage two at each falling edge
        for (int k = 0; k < n_rows + 2; k++) begin
            if (k >= 1 && k <= n_rows) begin
                check_fwd(k - 1);
                csr = csr_for_mode(rows[k - 1].mode);
            end
            if (k >= 2) begin
                check_wb(k - 2);
            end
            if (k < n_rows) begin
                drive_row(k);
            end else begin
                pass_in.is_flush = 1'b1;
                excp_in          = '0;
            end
            @(negedge clk);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/mem_pkg.sv
rtl/dcache_req_if.sv
rtl/tlb_array.sv
rtl/addr_trans.sv
rtl/memory1_stage.sv
rtl/data_store.sv
rtl/memory2_stage.sv
rtl/mem_top.sv
+incdir+dv
dv/mem_tb.sv
